// ==== nabp_pkg.sv ====
package nabp_pkg;

    // fixed geometry
    localparam int K_ANGLES    = 8;
    localparam int K_S_LEN     = 16;
    localparam int K_IMG_DIM   = 8;
    // trig table is Q1.6
    localparam int K_TRIG_FRAC = 6;

    // raw sinogram sample
    typedef logic [11:0]        data_t;
    // filtered sample, signed after the high-pass
    typedef logic signed [15:0] fdata_t;
    typedef logic [2:0]         angle_t;
    // detector bin within a line
    typedef logic [3:0]         bin_t;
    // pixel coordinate, row or column
    typedef logic [2:0]         coord_t;
    // pixel accumulator
    typedef logic signed [23:0] pix_t;
    // row * 8 + column
    typedef logic [5:0]         img_addr_t;
    typedef logic signed [7:0]  trig_t;

    // cos and sin of k * 22.5 deg, rounded
    localparam trig_t K_COS [K_ANGLES] = '{
        8'sd64, 8'sd59, 8'sd45, 8'sd24, 8'sd0, -8'sd24, -8'sd45, -8'sd59
    };
    localparam trig_t K_SIN [K_ANGLES] = '{
        8'sd0, 8'sd24, 8'sd45, 8'sd59, 8'sd64, 8'sd59, 8'sd45, 8'sd24
    };

    // sideband that rides along with each sample
    typedef struct packed {
        logic   valid;
        logic   last;
        logic   bank;
        bin_t   s;
        angle_t angle;
    } line_tag_t;

    // one pixel visit, broadcast to all processing elements
    typedef struct packed {
        logic   valid;
        logic   last;
        logic   bank;
        coord_t x;
        coord_t r;
        angle_t angle;
    } scan_t;

    typedef enum logic [1:0] {SA_IDLE, SA_RUN, SA_WAIT_CREDIT} sa_state_t;
    typedef enum logic [1:0] {PSC_IDLE, PSC_WAIT_BANK, PSC_SCAN, PSC_DRAIN} psc_state_t;

endpackage

// ==== nabp_sinogram_addresser.sv ====
module nabp_sinogram_addresser (
    input  logic                clk,
    input  logic                rst,
    input  logic                kick,
    input  logic                credit_return,
    output logic [6:0]          sg_addr,
    output nabp_pkg::line_tag_t tag
);
    import nabp_pkg::*;

    sa_state_t  state;
    angle_t     angle;
    bin_t       s;
    logic       bank;
    logic [1:0] credits;
    logic       active;
    logic       line_start;
    logic       line_end;
    logic       run_end;
    logic       issue;
    logic       spend;

    // address is angle * 16 + s, held while stalled
    assign sg_addr    = {angle, s};
    assign active     = (state == SA_RUN) || (state == SA_WAIT_CREDIT);
    assign line_start = (s == '0);
    assign line_end   = (s == bin_t'(K_S_LEN - 1));
    assign run_end    = line_end && (angle == angle_t'(K_ANGLES - 1));
    // a line may only begin with a free bank in hand
    assign issue      = active && (!line_start || credits != 2'd0);
    assign spend      = issue && line_start;

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= SA_IDLE;
            angle   <= '0;
            s       <= '0;
            bank    <= 1'b0;
            credits <= 2'd2;
            tag     <= '0;
        end else begin
            // one credit out per line, one back per released bank
            credits <= credits - 2'(spend) + 2'(credit_return);
            // tag lines up with sg_val one cycle later
            tag.valid <= issue;
            tag.last  <= issue && line_end;
            tag.bank  <= bank;
            tag.s     <= s;
            tag.angle <= angle;
            case (state)
                SA_IDLE: begin
                    // all banks back means the previous run is fully processed
                    if (kick && credits == 2'd2) begin
                        state <= SA_RUN;
                        angle <= '0;
                        s     <= '0;
                        bank  <= 1'b0;
                    end
                end
                default: begin
                    if (!issue) begin
                        state <= SA_WAIT_CREDIT;
                    end else if (run_end) begin
                        // last address stays on the port
                        state <= SA_IDLE;
                    end else begin
                        state <= SA_RUN;
                        s     <= s + 1'b1;
                        // banks alternate line by line
                        if (line_end) begin
                            angle <= angle + 1'b1;
                            bank  <= ~bank;
                        end
                    end
                end
            endcase
        end
    end

    // releases never outrun the lines handed out
    a_credit_max : assert property (@(posedge clk) disable iff (rst) credits <= 2'd2);

endmodule

// ==== nabp_filter.sv ====
module nabp_filter (
    input  logic                clk,
    input  logic                rst,
    input  nabp_pkg::data_t     val_in,
    input  nabp_pkg::line_tag_t tag_in,
    output nabp_pkg::fdata_t    val_out,
    output nabp_pkg::line_tag_t tag_out
);
    import nabp_pkg::*;

    // x[s-1] and x[s-2]
    data_t  x1;
    data_t  x2;
    data_t  xm1;
    data_t  xm2;
    logic   line_start;
    fdata_t y;

    // zeros before the start of each line
    assign line_start = (tag_in.s == '0);
    assign xm1        = line_start ? '0 : x1;
    assign xm2        = line_start ? '0 : x2;

    // 2x[s] - x[s-1] - x[s-2]
    assign y = (fdata_t'({4'b0000, val_in}) <<< 1)
             - fdata_t'({4'b0000, xm1})
             - fdata_t'({4'b0000, xm2});

    always_ff @(posedge clk) begin
        if (rst) begin
            tag_out <= '0;
        end else begin
            tag_out <= tag_in;
        end
    end

    always_ff @(posedge clk) begin
        // history only moves on real samples
        if (tag_in.valid) begin
            x1 <= val_in;
            x2 <= xm1;
        end
        val_out <= y;
    end

endmodule

// ==== nabp_filtered_ram.sv ====
module nabp_filtered_ram #(
    parameter int n_pe = 2
) (
    input  logic                clk,
    input  logic                rst,
    input  nabp_pkg::fdata_t    wr_val,
    input  nabp_pkg::line_tag_t wr_tag,
    input  logic                release_stb,
    input  logic                release_bank,
    output logic [1:0]          bank_full,
    output nabp_pkg::angle_t    bank_angle [2],
    input  logic                rd_bank,
    input  nabp_pkg::bin_t      rd_bin [n_pe],
    output nabp_pkg::fdata_t    rd_val [n_pe]
);
    import nabp_pkg::*;

    // ping-pong line store
    fdata_t mem [2][K_S_LEN];
    logic   line_done;

    assign line_done = wr_tag.valid && wr_tag.last;

    always_ff @(posedge clk) begin
        if (wr_tag.valid) begin
            mem[wr_tag.bank][wr_tag.s] <= wr_val;
        end
        // angle travels with the bank it was filtered into
        if (line_done) begin
            bank_angle[wr_tag.bank] <= wr_tag.angle;
        end
    end

    // full on last sample, empty on release
    always_ff @(posedge clk) begin
        if (rst) begin
            bank_full <= 2'b00;
        end else begin
            for (int b = 0; b < 2; b++) begin
                if (line_done && wr_tag.bank == 1'(b)) begin
                    bank_full[b] <= 1'b1;
                end else if (release_stb && release_bank == 1'(b)) begin
                    bank_full[b] <= 1'b0;
                end
            end
        end
    end

    // one combinational tap per processing element
    always_comb begin
        for (int i = 0; i < n_pe; i++) begin
            rd_val[i] = mem[rd_bank][rd_bin[i]];
        end
    end

    // credits keep the producer off a bank still being scanned
    a_no_overwrite : assert property (@(posedge clk) disable iff (rst)
        wr_tag.valid |-> !bank_full[wr_tag.bank]);

endmodule

// ==== nabp_processing_swap_control.sv ====
module nabp_processing_swap_control #(
    parameter int n_pe = 2
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             kick,
    input  logic [1:0]       bank_full,
    input  nabp_pkg::angle_t bank_angle [2],
    output nabp_pkg::scan_t  scan,
    output logic             release_stb,
    output logic             release_bank,
    output logic             done
);
    import nabp_pkg::*;

    // image rows owned by each element
    localparam int ROWS = K_IMG_DIM / n_pe;

    psc_state_t state;
    logic       exp_bank;
    angle_t     angle_cnt;
    coord_t     x;
    coord_t     r;
    logic [1:0] drain_cnt;
    logic       scan_end;

    assign release_bank = exp_bank;
    assign scan_end     = (x == coord_t'(K_IMG_DIM - 1)) && (r == coord_t'(ROWS - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= PSC_IDLE;
            exp_bank    <= 1'b0;
            angle_cnt   <= '0;
            x           <= '0;
            r           <= '0;
            drain_cnt   <= '0;
            scan        <= '0;
            release_stb <= 1'b0;
            done        <= 1'b0;
        end else begin
            // other scan fields hold, bank select stays put during drain
            scan.valid  <= 1'b0;
            release_stb <= 1'b0;
            case (state)
                PSC_IDLE: begin
                    if (kick) begin
                        state     <= PSC_WAIT_BANK;
                        exp_bank  <= 1'b0;
                        angle_cnt <= '0;
                        done      <= 1'b0;
                    end
                end
                PSC_WAIT_BANK: begin
                    // strict bank order, same as the producer
                    if (bank_full[exp_bank]) begin
                        state <= PSC_SCAN;
                        x     <= '0;
                        r     <= '0;
                    end
                end
                PSC_SCAN: begin
                    scan.valid <= 1'b1;
                    scan.last  <= scan_end;
                    scan.bank  <= exp_bank;
                    scan.x     <= x;
                    scan.r     <= r;
                    scan.angle <= bank_angle[exp_bank];
                    // raster over the local band
                    if (scan_end) begin
                        state     <= PSC_DRAIN;
                        drain_cnt <= '0;
                    end else if (x == coord_t'(K_IMG_DIM - 1)) begin
                        x <= '0;
                        r <= r + 1'b1;
                    end else begin
                        x <= x + 1'b1;
                    end
                end
                PSC_DRAIN: begin
                    // two cycles for the element pipeline, then release
                    drain_cnt <= drain_cnt + 1'b1;
                    if (drain_cnt == 2'd1) begin
                        release_stb <= 1'b1;
                    end
                    if (drain_cnt == 2'd2) begin
                        exp_bank  <= ~exp_bank;
                        angle_cnt <= angle_cnt + 1'b1;
                        if (angle_cnt == angle_t'(K_ANGLES - 1)) begin
                            state <= PSC_IDLE;
                            done  <= 1'b1;
                        end else begin
                            state <= PSC_WAIT_BANK;
                        end
                    end
                end
                default: state <= PSC_IDLE;
            endcase
        end
    end

    // release lands in drain, on a bank that is still marked full
    a_release_drain : assert property (@(posedge clk) disable iff (rst)
        release_stb |-> (state == PSC_DRAIN) && bank_full[release_bank]);

endmodule

// ==== nabp_processing_element.sv ====
module nabp_processing_element #(
    parameter int n_pe  = 2,
    parameter int pe_id = 0
) (
    input  logic                clk,
    input  logic                rst,
    input  nabp_pkg::scan_t     scan,
    output nabp_pkg::bin_t      rd_bin,
    input  nabp_pkg::fdata_t    rd_val,
    input  nabp_pkg::img_addr_t img_rd_addr,
    input  nabp_pkg::pix_t      chain_in,
    output nabp_pkg::pix_t      chain_out
);
    import nabp_pkg::*;

    localparam int ROWS   = K_IMG_DIM / n_pe;
    localparam int DEPTH  = ROWS * K_IMG_DIM;
    localparam int IW     = $clog2(DEPTH);
    // first global row of this band
    localparam int ROW_LO = pe_id * ROWS;

    // local band of pixels, indexed r * 8 + x
    pix_t            acc [DEPTH];
    int              xc;
    int              yc;
    int              proj;
    int              s_full;
    logic            in_range;
    logic            s1_valid;
    logic            s1_first;
    logic            s1_in_range;
    bin_t            s1_bin;
    logic [IW-1:0]   s1_idx;
    pix_t            addend;
    coord_t          rd_row;
    logic            rd_own;
    logic [IW-1:0]   rd_idx;
    pix_t            rd_word;
    logic            rd_own_q;

    // nearest bin, centred on the middle of the image
    always_comb begin
        xc       = int'(scan.x) - K_IMG_DIM / 2;
        yc       = ROW_LO + int'(scan.r) - K_IMG_DIM / 2;
        proj     = xc * int'(K_COS[scan.angle]) + yc * int'(K_SIN[scan.angle]);
        s_full   = (proj >>> K_TRIG_FRAC) + K_S_LEN / 2;
        in_range = (s_full >= 0) && (s_full < K_S_LEN);
    end

    // stage 1, bin request
    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= scan.valid;
        end
    end

    always_ff @(posedge clk) begin
        s1_first    <= (scan.angle == '0);
        s1_in_range <= in_range;
        s1_bin      <= bin_t'(s_full);
        s1_idx      <= IW'(int'(scan.r) * K_IMG_DIM + int'(scan.x));
    end

    assign rd_bin = s1_bin;
    // out of range bins add nothing
    assign addend = s1_in_range ? pix_t'(rd_val) : '0;

    // stage 2, accumulate; angle 0 overwrites so each run starts clean
    always_ff @(posedge clk) begin
        if (s1_valid) begin
            acc[s1_idx] <= s1_first ? addend : acc[s1_idx] + addend;
        end
    end

    // image read port
    assign rd_row = img_rd_addr[5:3];
    assign rd_own = (int'(rd_row) >= ROW_LO) && (int'(rd_row) < ROW_LO + ROWS);
    assign rd_idx = IW'((int'(rd_row) - ROW_LO) * K_IMG_DIM + int'(img_rd_addr[2:0]));

    always_ff @(posedge clk) begin
        rd_word <= acc[rd_idx];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_own_q <= 1'b0;
        end else begin
            rd_own_q <= rd_own;
        end
    end

    // owner puts its word on the chain, others pass through
    assign chain_out = rd_own_q ? rd_word : chain_in;

endmodule

// ==== nabp_top.sv ====
module nabp_top #(
    parameter int n_pe = 2
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                kick,
    output logic [6:0]          sg_addr,
    input  nabp_pkg::data_t     sg_val,
    output logic                done,
    input  nabp_pkg::img_addr_t img_rd_addr,
    output nabp_pkg::pix_t      img_rd_val
);
    import nabp_pkg::*;

    line_tag_t  sa_tag;
    line_tag_t  fl_tag;
    fdata_t     fl_val;
    logic       release_stb;
    logic       release_bank;
    logic [1:0] bank_full;
    angle_t     bank_angle [2];
    scan_t      scan;
    bin_t       pe_rd_bin [n_pe];
    fdata_t     pe_rd_val [n_pe];
    // image read chain, element 0 first
    pix_t       chain [n_pe + 1];

    // producer side, one credit per released bank
    nabp_sinogram_addresser sinogram_addresser (
        .clk           (clk),
        .rst           (rst),
        .kick          (kick),
        .credit_return (release_stb),
        .sg_addr       (sg_addr),
        .tag           (sa_tag)
    );

    nabp_filter filter (
        .clk     (clk),
        .rst     (rst),
        .val_in  (sg_val),
        .tag_in  (sa_tag),
        .val_out (fl_val),
        .tag_out (fl_tag)
    );

    // read bank follows the scan stream, held through the drain
    nabp_filtered_ram #(.n_pe(n_pe)) filtered_ram_swap_control (
        .clk          (clk),
        .rst          (rst),
        .wr_val       (fl_val),
        .wr_tag       (fl_tag),
        .release_stb  (release_stb),
        .release_bank (release_bank),
        .bank_full    (bank_full),
        .bank_angle   (bank_angle),
        .rd_bank      (scan.bank),
        .rd_bin       (pe_rd_bin),
        .rd_val       (pe_rd_val)
    );

    nabp_processing_swap_control #(.n_pe(n_pe)) processing_swap_control (
        .clk          (clk),
        .rst          (rst),
        .kick         (kick),
        .bank_full    (bank_full),
        .bank_angle   (bank_angle),
        .scan         (scan),
        .release_stb  (release_stb),
        .release_bank (release_bank),
        .done         (done)
    );

    assign chain[0]   = '0;
    assign img_rd_val = chain[n_pe];

    // one element per row band
    for (genvar i = 0; i < n_pe; i++) begin : g_pe
        nabp_processing_element #(.n_pe(n_pe), .pe_id(i)) processing_element (
            .clk         (clk),
            .rst         (rst),
            .scan        (scan),
            .rd_bin      (pe_rd_bin[i]),
            .rd_val      (pe_rd_val[i]),
            .img_rd_addr (img_rd_addr),
            .chain_in    (chain[i]),
            .chain_out   (chain[i + 1])
        );
    end

endmodule

// ==== nabp_tb.sv ====
module nabp_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import nabp_pkg::*;

    localparam int N_PE    = 2;
    localparam int TIMEOUT = 5000;
    localparam int N_PIX   = K_IMG_DIM * K_IMG_DIM;
    localparam int N_SG    = K_ANGLES * K_S_LEN;

    logic       clk;
    logic       rst;
    logic       kick;
    logic [6:0] sg_addr;
    data_t      sg_val;
    logic       done;
    img_addr_t  img_rd_addr;
    pix_t       img_rd_val;

    // stored sinogram and expected image
    data_t       sino [N_SG];
    int          model_img [N_PIX];
    logic [6:0]  addr_seen [$];
    int          err_count;
    int          timeout_count;

    nabp_top #(.n_pe(N_PE)) DUT (
        .clk         (clk),
        .rst         (rst),
        .kick        (kick),
        .sg_addr     (sg_addr),
        .sg_val      (sg_val),
        .done        (done),
        .img_rd_addr (img_rd_addr),
        .img_rd_val  (img_rd_val)
    );

    always #2 clk = ~clk;

    // sinogram RAM, answers one cycle after the address
    always @(posedge clk) begin
        sg_val <= sino[sg_addr];
    end

    function automatic void fill_sino(input bit zero);
        for (int i = 0; i < N_SG; i++) begin
            sino[i] = zero ? data_t'(0) : data_t'($urandom());
        end
    endfunction

    // high-pass each line, then smear by nearest bin
    function automatic void build_model();
        int filt [K_ANGLES][K_S_LEN];
        int prev1;
        int prev2;
        int proj;
        int bin;
        int acc;
        for (int a = 0; a < K_ANGLES; a++) begin
            for (int s = 0; s < K_S_LEN; s++) begin
                prev1 = (s >= 1) ? int'(sino[a * K_S_LEN + s - 1]) : 0;
                prev2 = (s >= 2) ? int'(sino[a * K_S_LEN + s - 2]) : 0;
                filt[a][s] = 2 * int'(sino[a * K_S_LEN + s]) - prev1 - prev2;
            end
        end
        for (int y = 0; y < K_IMG_DIM; y++) begin
            for (int x = 0; x < K_IMG_DIM; x++) begin
                acc = 0;
                for (int a = 0; a < K_ANGLES; a++) begin
                    proj = (x - 4) * int'(K_COS[a]) + (y - 4) * int'(K_SIN[a]);
                    bin  = (proj >>> K_TRIG_FRAC) + K_S_LEN / 2;
                    // outside the detector adds nothing
                    if (bin >= 0 && bin < K_S_LEN) begin
                        acc += filt[a][bin];
                    end
                end
                model_img[y * K_IMG_DIM + x] = acc;
            end
        end
    endfunction

    // stall repeats collapsed, so the list must be 0..127
    task automatic check_addrs();
        assert (addr_seen.size() == N_SG) else begin
            err_count++;
            $display("** Error @ %0t: %0d distinct addresses seen, expected %0d",
                     $time, addr_seen.size(), N_SG);
        end
        for (int i = 0; i < addr_seen.size() && i < N_SG; i++) begin
            assert (int'(addr_seen[i]) == i) else begin
                err_count++;
                $display("** Error @ %0t: address %0d is %0d, expected %0d",
                         $time, i, addr_seen[i], i);
            end
        end
    endtask

    // read port is one cycle, sample two edges after the drive
    task automatic read_image();
        for (int i = 0; i < N_PIX + 2; i++) begin
            @(posedge clk);
            if (i >= 2) begin
                assert (int'(img_rd_val) == model_img[i - 2]) else begin
                    err_count++;
                    $display("** Error @ %0t: pixel %0d is %0d, expected %0d",
                             $time, i - 2, img_rd_val, model_img[i - 2]);
                end
            end
            if (i < N_PIX) begin
                img_rd_addr <= img_addr_t'(i);
            end
        end
    endtask

    task automatic run_case(input bit zero, input bit busy_kick);
        bit seen;
        seen = 1'b0;
        if (timeout_count != 0) begin
            return;
        end
        // new sinogram while the engine is idle
        @(negedge clk);
        fill_sino(zero);
        build_model();
        addr_seen.delete();
        @(posedge clk);
        kick <= 1'b1;
        @(posedge clk);
        kick <= 1'b0;
        for (int cyc = 0; cyc < TIMEOUT; cyc++) begin
            @(posedge clk);
            if (cyc == 0) begin
                // done drops the cycle after the kick
                assert (done == 1'b0) else begin
                    err_count++;
                    $display("** Error @ %0t: done still high after kick", $time);
                end
            end else if (done) begin
                seen = 1'b1;
                break;
            end
            if (addr_seen.size() == 0 || addr_seen[$] != sg_addr) begin
                addr_seen.push_back(sg_addr);
            end
            // extra kicks mid-run must be ignored
            kick <= busy_kick && (cyc == 20 || cyc == 200);
        end
        kick <= 1'b0;
        if (!seen) begin
            timeout_count++;
            $display("timeout: done did not rise within %0d cycles of the kick", TIMEOUT);
            return;
        end
        // done holds until the next kick
        repeat (5) begin
            @(posedge clk);
            assert (done == 1'b1) else begin
                err_count++;
                $display("** Error @ %0t: done fell without a kick", $time);
            end
        end
        check_addrs();
        read_image();
    endtask

    initial begin
        clk           = 1'b0;
        rst           = 1'b1;
        kick          = 1'b0;
        img_rd_addr   = '0;
        sg_val        = '0;
        err_count     = 0;
        timeout_count = 0;
        void'($urandom(22726));
        fill_sino(1'b1);
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        assert (done == 1'b0) else begin
            err_count++;
            $display("** Error @ %0t: done high after reset", $time);
        end
        // two random runs back to back, then busy kicks, then zeros
        run_case(1'b0, 1'b0);
        run_case(1'b0, 1'b0);
        run_case(1'b0, 1'b1);
        run_case(1'b1, 1'b0);
        $display("errors: %0d, timeouts: %0d", err_count, timeout_count);
        if (err_count == 0 && timeout_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
nabp_pkg.sv
nabp_sinogram_addresser.sv
nabp_filter.sv
nabp_filtered_ram.sv
nabp_processing_swap_control.sv
nabp_processing_element.sv
nabp_top.sv
nabp_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module nabp_tb -f flist.f -o nabp_sim

./obj_dir/nabp_sim | tee sim.log

if grep -q "TESTS PASSED" sim.log; then
    exit 0
else
    exit 1
fi
